//--- ddr3_pin_pkg.sv
package ddr3_pin_pkg;

    // Device side pin widths
    localparam int ROW_BITS = 14;   // A[13:0]
    localparam int BA_BITS  = 3;    // BA[2:0], eight banks

    // One command slot holds the four strobes, then odt, cke and reset_n,
    // then the bank and the row address
    localparam int CMD_LEN = 4 + 3 + BA_BITS + ROW_BITS;

    // Control strobes counted down from the top bit of a slot
    localparam int CMD_CS_N    = CMD_LEN - 1;
    localparam int CMD_RAS_N   = CMD_LEN - 2;
    localparam int CMD_CAS_N   = CMD_LEN - 3;
    localparam int CMD_WE_N    = CMD_LEN - 4;
    localparam int CMD_ODT     = CMD_LEN - 5;   // On-die termination
    localparam int CMD_CKE     = CMD_LEN - 6;   // Clock enable
    localparam int CMD_RESET_N = CMD_LEN - 7;   // Device reset, active low

    // Address fields at the bottom of the slot
    localparam int CMD_BANK_LSB = ROW_BITS;     // Bank sits right above the row
    localparam int CMD_ROW_LSB  = 0;            // Row starts at bit 0

    // One slot is what the pins carry for a single DDR3 clock
    typedef logic [CMD_LEN-1:0] cmd_slot_t;

    // Pin fields
    typedef logic [ROW_BITS-1:0] row_addr_t;   // o_ddr3_addr
    typedef logic [BA_BITS-1:0]  bank_addr_t;  // o_ddr3_ba_addr

endpackage

//--- phy_serdes_pkg.sv
package phy_serdes_pkg;

    // Clock ratio between the controller and the DDR3 side
    localparam int SERDES_RATIO = 4;                 // DDR3 clocks per controller clock
    localparam int DATA_BEATS   = 2 * SERDES_RATIO;  // Two beats per DDR3 clock

    // Lane geometry
    localparam int LANES    = 2;
    localparam int DQ_BITS  = 8;                 // One byte lane
    localparam int DQ_WIDTH = LANES * DQ_BITS;   // All DQ pins

    // Four command slots, slot n at bits [n*CMD_LEN +: CMD_LEN]
    typedef logic [ddr3_pin_pkg::CMD_LEN*SERDES_RATIO-1:0] cmd_bus_t;

    // One beat across every DQ pin
    typedef logic [DQ_WIDTH-1:0] dq_bus_t;

    // All beats of a single pin in one frame, beat 0 in bit 0
    typedef logic [DATA_BEATS-1:0] beat_word_t;

    // Controller data word
    // slice n at [n*DQ_WIDTH +: DQ_WIDTH] carries beat n
    typedef logic [DQ_WIDTH*DATA_BEATS-1:0] ctrl_data_t;

    // One flag per byte lane, also the DQS pin vector
    typedef logic [LANES-1:0] lane_mask_t;

    // DQS samples, lane l in byte l and beat n in bit n of that byte
    typedef logic [LANES*DATA_BEATS-1:0] dqs_bus_t;

endpackage

//--- cmd_slot_decode.sv
`timescale 1ns/1ns

module cmd_slot_decode (
    input  logic                     i_controller_clk,
    input  logic                     i_ddr3_clk,
    input  logic                     i_rst_n,
    input  phy_serdes_pkg::cmd_bus_t i_controller_cmd,   // Four slots per controller cycle
    output logic                     o_ddr3_cs_n,
    output logic                     o_ddr3_ras_n,
    output logic                     o_ddr3_cas_n,
    output logic                     o_ddr3_we_n,
    output logic                     o_ddr3_odt,
    output logic                     o_ddr3_cke,
    output logic                     o_ddr3_reset_n,
    output ddr3_pin_pkg::bank_addr_t o_ddr3_ba_addr,
    output ddr3_pin_pkg::row_addr_t  o_ddr3_addr
);

    logic                     ctl_toggle;    // Flips on every controller edge
    logic [3:0]               toggle_sync;   // Toggle seen through the DDR3 clock
    logic                     frame_start;   // DDR3 cycle 0 of a controller cycle
    logic                     frame_seen;
    logic [$clog2(phy_serdes_pkg::SERDES_RATIO)-1:0] slot_cnt, slot_idx;
    phy_serdes_pkg::cmd_bus_t cmd_q;         // Controller side capture
    phy_serdes_pkg::cmd_bus_t cmd_shadow;    // Held for cycles 1 to 3
    phy_serdes_pkg::cmd_bus_t cmd_src;
    ddr3_pin_pkg::cmd_slot_t  slot_q;        // Slot on the pins

    always_ff @(posedge i_controller_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ctl_toggle <= 1'b0;
            cmd_q      <= '0;
        end else begin
            ctl_toggle <= ~ctl_toggle;
            cmd_q      <= i_controller_cmd;
        end
    end

    // Fourth stage changes exactly on the DDR3 edge that lines up with the next controller edge
    assign frame_start = toggle_sync[3] ^ toggle_sync[2];
    assign slot_idx    = frame_start ? '0 : slot_cnt;      // Realign on every frame
    assign cmd_src     = frame_start ? cmd_q : cmd_shadow; // Shadow not loaded yet on cycle 0

    // SDR output, one slot per DDR3 clock
    always_ff @(posedge i_ddr3_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            toggle_sync <= '0;
            slot_cnt    <= '0;
            frame_seen  <= 1'b0;
            cmd_shadow  <= '0;
            slot_q      <= '0;   // All pins low, device held in reset
        end else begin
            toggle_sync <= {toggle_sync[2:0], ctl_toggle};
            slot_cnt    <= slot_idx + 1'b1;
            if (frame_start) begin
                frame_seen <= 1'b1;
                cmd_shadow <= cmd_q;
            end
            slot_q <= cmd_src[slot_idx*ddr3_pin_pkg::CMD_LEN +: ddr3_pin_pkg::CMD_LEN];
        end
    end

    // Split the slot into the DDR3 pins
    assign o_ddr3_cs_n    = slot_q[ddr3_pin_pkg::CMD_CS_N];
    assign o_ddr3_ras_n   = slot_q[ddr3_pin_pkg::CMD_RAS_N];
    assign o_ddr3_cas_n   = slot_q[ddr3_pin_pkg::CMD_CAS_N];
    assign o_ddr3_we_n    = slot_q[ddr3_pin_pkg::CMD_WE_N];
    assign o_ddr3_odt     = slot_q[ddr3_pin_pkg::CMD_ODT];
    assign o_ddr3_cke     = slot_q[ddr3_pin_pkg::CMD_CKE];
    assign o_ddr3_reset_n = slot_q[ddr3_pin_pkg::CMD_RESET_N];
    assign o_ddr3_ba_addr = slot_q[ddr3_pin_pkg::CMD_BANK_LSB +: ddr3_pin_pkg::BA_BITS];
    assign o_ddr3_addr    = slot_q[ddr3_pin_pkg::CMD_ROW_LSB +: ddr3_pin_pkg::ROW_BITS];

    // Free running slot count stays locked to the controller clock
    a_slot_aligned : assert property (@(posedge i_ddr3_clk) disable iff (!i_rst_n)
        (frame_start && frame_seen) |-> (slot_cnt == '0))
        else $error("Command slot count out of step with controller clock");

endmodule

//--- dq_write_serializer.sv
`timescale 1ns/1ns

module dq_write_serializer (
    input  logic                       i_controller_clk,
    input  logic                       i_ddr3_clk,
    input  logic                       i_rst_n,
    input  phy_serdes_pkg::ctrl_data_t i_controller_data,             // Eight beats of DQ
    input  logic                       i_controller_dq_tri_control,   // High releases DQ
    input  logic                       i_controller_dqs_tri_control,  // High releases DQS
    input  logic                       i_controller_toggle_dqs,
    inout  phy_serdes_pkg::dq_bus_t    io_ddr3_dq,
    inout  phy_serdes_pkg::lane_mask_t io_ddr3_dqs,
    inout  phy_serdes_pkg::lane_mask_t io_ddr3_dqs_n
);

    logic                       ctl_toggle;
    logic [3:0]                 toggle_sync;
    logic                       frame_start;
    logic                       frame_seen;
    logic [$clog2(phy_serdes_pkg::SERDES_RATIO)-1:0] beat_cnt, beat_idx;  // DDR3 cycle in frame
    logic                       dq_tri_q, dqs_tri_q, toggle_q;   // Controller side levels
    logic                       dq_tri_r, dqs_tri_r, toggle_r;   // Levels for current frame
    phy_serdes_pkg::ctrl_data_t data_q;
    phy_serdes_pkg::ctrl_data_t data_shadow;
    phy_serdes_pkg::ctrl_data_t data_src;
    phy_serdes_pkg::dq_bus_t    even_q, odd_q;    // Beat 2m and beat 2m+1
    phy_serdes_pkg::dq_bus_t    dq_out;
    phy_serdes_pkg::lane_mask_t dqs_out;

    always_ff @(posedge i_controller_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ctl_toggle <= 1'b0;
            dq_tri_q   <= 1'b1;   // Released out of reset
            dqs_tri_q  <= 1'b1;
            toggle_q   <= 1'b0;
        end else begin
            ctl_toggle <= ~ctl_toggle;
            dq_tri_q   <= i_controller_dq_tri_control;
            dqs_tri_q  <= i_controller_dqs_tri_control;
            toggle_q   <= i_controller_toggle_dqs;
        end
    end

    always_ff @(posedge i_controller_clk) begin
        data_q <= i_controller_data;
    end

    assign frame_start = toggle_sync[3] ^ toggle_sync[2];   // Lands on DDR3 cycle 0
    assign beat_idx    = frame_start ? '0 : beat_cnt;
    assign data_src    = frame_start ? data_q : data_shadow;

    always_ff @(posedge i_ddr3_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            toggle_sync <= '0;
            beat_cnt    <= '0;
            frame_seen  <= 1'b0;
            dq_tri_r    <= 1'b1;
            dqs_tri_r   <= 1'b1;
            toggle_r    <= 1'b0;
        end else begin
            toggle_sync <= {toggle_sync[2:0], ctl_toggle};
            beat_cnt    <= beat_idx + 1'b1;
            if (frame_start) begin
                frame_seen <= 1'b1;
                dq_tri_r   <= dq_tri_q;    // Held for the whole controller cycle
                dqs_tri_r  <= dqs_tri_q;
                toggle_r   <= toggle_q;
            end
        end
    end

    // Beat pair for this DDR3 clock
    always_ff @(posedge i_ddr3_clk) begin
        if (frame_start)
            data_shadow <= data_q;
        even_q <= data_src[(2*beat_idx)*phy_serdes_pkg::DQ_WIDTH +: phy_serdes_pkg::DQ_WIDTH];
        odd_q  <= data_src[(2*beat_idx+1)*phy_serdes_pkg::DQ_WIDTH +: phy_serdes_pkg::DQ_WIDTH];
    end

    // Clock level picks the half, high half carries the even beat
    assign dq_out  = i_ddr3_clk ? even_q : odd_q;
    assign dqs_out = {phy_serdes_pkg::LANES{i_ddr3_clk & toggle_r}};  // 1,0,1,0 per DDR3 clock

    assign io_ddr3_dq    = dq_tri_r  ? 'z : dq_out;
    assign io_ddr3_dqs   = dqs_tri_r ? 'z : dqs_out;
    assign io_ddr3_dqs_n = dqs_tri_r ? 'z : ~dqs_out;   // Differential partner

    a_beat_aligned : assert property (@(posedge i_ddr3_clk) disable iff (!i_rst_n)
        (frame_start && frame_seen) |-> (beat_cnt == '0))
        else $error("Write beat index out of step with controller clock");

endmodule

//--- dq_read_deserializer.sv
`timescale 1ns/1ns

module dq_read_deserializer (
    input  logic                       i_controller_clk,
    input  logic                       i_ddr3_clk,
    input  logic                       i_rst_n,
    inout  phy_serdes_pkg::dq_bus_t    io_ddr3_dq,     // Sampled only
    inout  phy_serdes_pkg::lane_mask_t io_ddr3_dqs,    // Sampled only
    input  phy_serdes_pkg::lane_mask_t i_controller_bitslip,
    output phy_serdes_pkg::ctrl_data_t o_controller_iserdes_data,
    output phy_serdes_pkg::dqs_bus_t   o_controller_iserdes_dqs
);

    logic                       ctl_toggle;
    logic [3:0]                 toggle_sync;
    logic                       frame_start;
    phy_serdes_pkg::dq_bus_t    dq_fall;        // Falling edge samples
    phy_serdes_pkg::lane_mask_t dqs_fall;
    phy_serdes_pkg::beat_word_t dq_hist  [phy_serdes_pkg::DQ_WIDTH];  // Last eight beats, bit 0 oldest
    phy_serdes_pkg::beat_word_t dqs_hist [phy_serdes_pkg::LANES];
    phy_serdes_pkg::beat_word_t dq_snap  [phy_serdes_pkg::DQ_WIDTH];  // Frame held for controller side
    phy_serdes_pkg::beat_word_t dqs_snap [phy_serdes_pkg::LANES];
    phy_serdes_pkg::lane_mask_t slip_q;
    logic [$clog2(phy_serdes_pkg::DATA_BEATS)-1:0] slip_off [phy_serdes_pkg::LANES];
    phy_serdes_pkg::ctrl_data_t data_next;
    phy_serdes_pkg::dqs_bus_t   dqs_next;

    // Bit n of the result is beat n+off of the word
    function automatic phy_serdes_pkg::beat_word_t rotate_beats(
        input phy_serdes_pkg::beat_word_t                 word,
        input logic [$clog2(phy_serdes_pkg::DATA_BEATS)-1:0] off
    );
        logic [2*phy_serdes_pkg::DATA_BEATS-1:0] dbl;
        dbl = {word, word} >> off;
        return dbl[phy_serdes_pkg::DATA_BEATS-1:0];
    endfunction

    always_ff @(posedge i_controller_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            ctl_toggle <= 1'b0;
        else
            ctl_toggle <= ~ctl_toggle;
    end

    always_ff @(posedge i_ddr3_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            toggle_sync <= '0;
        else
            toggle_sync <= {toggle_sync[2:0], ctl_toggle};
    end

    assign frame_start = toggle_sync[3] ^ toggle_sync[2];

    always_ff @(negedge i_ddr3_clk) begin
        dq_fall  <= io_ddr3_dq;    // Even beat, high half of the clock
        dqs_fall <= io_ddr3_dqs;
    end

    // Two beats shift in per DDR3 clock, newest at the top
    always_ff @(posedge i_ddr3_clk) begin
        for (int i = 0; i < phy_serdes_pkg::DQ_WIDTH; i++) begin
            dq_hist[i] <= {io_ddr3_dq[i], dq_fall[i],
                           dq_hist[i][phy_serdes_pkg::DATA_BEATS-1:2]};
            if (frame_start)
                dq_snap[i] <= dq_hist[i];
        end
        for (int l = 0; l < phy_serdes_pkg::LANES; l++) begin
            dqs_hist[l] <= {io_ddr3_dqs[l], dqs_fall[l],
                            dqs_hist[l][phy_serdes_pkg::DATA_BEATS-1:2]};
            if (frame_start)
                dqs_snap[l] <= dqs_hist[l];
        end
    end

    // Apply each lane's slip offset and transpose into beat slices
    always_comb begin
        phy_serdes_pkg::beat_word_t rot;
        data_next = '0;
        dqs_next  = '0;
        for (int i = 0; i < phy_serdes_pkg::DQ_WIDTH; i++) begin
            rot = rotate_beats(dq_snap[i], slip_off[i / phy_serdes_pkg::DQ_BITS]);
            for (int n = 0; n < phy_serdes_pkg::DATA_BEATS; n++)
                data_next[n*phy_serdes_pkg::DQ_WIDTH + i] = rot[n];
        end
        for (int l = 0; l < phy_serdes_pkg::LANES; l++)
            dqs_next[l*phy_serdes_pkg::DATA_BEATS +: phy_serdes_pkg::DATA_BEATS] =
                rotate_beats(dqs_snap[l], slip_off[l]);
    end

    always_ff @(posedge i_controller_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slip_q                    <= '0;
            o_controller_iserdes_data <= '0;
            o_controller_iserdes_dqs  <= '0;
            for (int l = 0; l < phy_serdes_pkg::LANES; l++)
                slip_off[l] <= '0;
        end else begin
            slip_q <= i_controller_bitslip;   // Registered so a slip shows on the third edge
            for (int l = 0; l < phy_serdes_pkg::LANES; l++)
                if (slip_q[l])
                    slip_off[l] <= slip_off[l] + 1'b1;   // Boundary one beat later, wraps at 8
            o_controller_iserdes_data <= data_next;
            o_controller_iserdes_dqs  <= dqs_next;
        end
    end

    // Each slip needs a gap, back to back pulses would be merged by the controller logic
    a_slip_pulse : assert property (@(posedge i_controller_clk) disable iff (!i_rst_n)
        (i_controller_bitslip & $past(i_controller_bitslip)) == '0)
        else $error("Bitslip held high on two consecutive controller edges");

endmodule

//--- ddr3_phy.sv
`timescale 1ns/1ns

module ddr3_phy (
    input  logic                       i_controller_clk,
    input  logic                       i_ddr3_clk,      // Four times the controller clock
    input  logic                       i_rst_n,
    // Controller side
    input  phy_serdes_pkg::cmd_bus_t   i_controller_cmd,
    input  logic                       i_controller_dqs_tri_control,
    input  logic                       i_controller_dq_tri_control,
    input  logic                       i_controller_toggle_dqs,
    input  phy_serdes_pkg::ctrl_data_t i_controller_data,
    input  phy_serdes_pkg::lane_mask_t i_controller_bitslip,
    output phy_serdes_pkg::ctrl_data_t o_controller_iserdes_data,
    output phy_serdes_pkg::dqs_bus_t   o_controller_iserdes_dqs,
    // DDR3 device side
    output logic                       o_ddr3_reset_n,
    output logic                       o_ddr3_cke,
    output logic                       o_ddr3_cs_n,
    output logic                       o_ddr3_ras_n,
    output logic                       o_ddr3_cas_n,
    output logic                       o_ddr3_we_n,
    output ddr3_pin_pkg::row_addr_t    o_ddr3_addr,
    output ddr3_pin_pkg::bank_addr_t   o_ddr3_ba_addr,
    inout  phy_serdes_pkg::dq_bus_t    io_ddr3_dq,
    inout  phy_serdes_pkg::lane_mask_t io_ddr3_dqs,
    inout  phy_serdes_pkg::lane_mask_t io_ddr3_dqs_n,
    output logic                       o_ddr3_odt
);

    // Command decode, SDR on the command pins
    cmd_slot_decode u_cmd (
        .i_controller_clk (i_controller_clk),
        .i_ddr3_clk       (i_ddr3_clk),
        .i_rst_n          (i_rst_n),
        .i_controller_cmd (i_controller_cmd),
        .o_ddr3_cs_n      (o_ddr3_cs_n),
        .o_ddr3_ras_n     (o_ddr3_ras_n),
        .o_ddr3_cas_n     (o_ddr3_cas_n),
        .o_ddr3_we_n      (o_ddr3_we_n),
        .o_ddr3_odt       (o_ddr3_odt),
        .o_ddr3_cke       (o_ddr3_cke),
        .o_ddr3_reset_n   (o_ddr3_reset_n),
        .o_ddr3_ba_addr   (o_ddr3_ba_addr),
        .o_ddr3_addr      (o_ddr3_addr)
    );

    // Write path drives DQ and DQS when not released
    dq_write_serializer u_write (
        .i_controller_clk             (i_controller_clk),
        .i_ddr3_clk                   (i_ddr3_clk),
        .i_rst_n                      (i_rst_n),
        .i_controller_data            (i_controller_data),
        .i_controller_dq_tri_control  (i_controller_dq_tri_control),
        .i_controller_dqs_tri_control (i_controller_dqs_tri_control),
        .i_controller_toggle_dqs      (i_controller_toggle_dqs),
        .io_ddr3_dq                   (io_ddr3_dq),
        .io_ddr3_dqs                  (io_ddr3_dqs),
        .io_ddr3_dqs_n                (io_ddr3_dqs_n)
    );

    // Read path samples the same nets
    dq_read_deserializer u_read (
        .i_controller_clk          (i_controller_clk),
        .i_ddr3_clk                (i_ddr3_clk),
        .i_rst_n                   (i_rst_n),
        .io_ddr3_dq                (io_ddr3_dq),
        .io_ddr3_dqs               (io_ddr3_dqs),
        .i_controller_bitslip      (i_controller_bitslip),
        .o_controller_iserdes_data (o_controller_iserdes_data),
        .o_controller_iserdes_dqs  (o_controller_iserdes_dqs)
    );

endmodule

//--- tb_ddr3_phy.sv
`timescale 1ns/1ns

module tb_ddr3_phy;

    localparam int CTL_PERIOD  = 8;
    localparam int NUM_TESTS   = 8;
    localparam int WATCHDOG_NS = NUM_TESTS * 16 * CTL_PERIOD * 2;
    localparam int K_CMD = 0;   // Command slots
    localparam int K_WR  = 1;   // Write data and tristate
    localparam int K_RD  = 2;   // Read frames and bitslip
    localparam int DQW   = phy_serdes_pkg::DQ_WIDTH;
    localparam int BEATS = phy_serdes_pkg::DATA_BEATS;
    localparam int LBITS = phy_serdes_pkg::DQ_BITS;

    logic                       i_controller_clk = 1'b1;   // Rising edges line up
    logic                       i_ddr3_clk       = 1'b1;
    logic                       i_rst_n;
    phy_serdes_pkg::cmd_bus_t   i_controller_cmd;
    phy_serdes_pkg::ctrl_data_t i_controller_data;
    logic                       dq_tri, dqs_tri, toggle_dqs;
    phy_serdes_pkg::lane_mask_t i_controller_bitslip;
    phy_serdes_pkg::ctrl_data_t o_controller_iserdes_data;
    phy_serdes_pkg::dqs_bus_t   o_controller_iserdes_dqs;
    logic                       o_ddr3_reset_n, o_ddr3_cke, o_ddr3_cs_n, o_ddr3_ras_n;
    logic                       o_ddr3_cas_n, o_ddr3_we_n, o_ddr3_odt;
    ddr3_pin_pkg::row_addr_t    o_ddr3_addr;
    ddr3_pin_pkg::bank_addr_t   o_ddr3_ba_addr;
    wire phy_serdes_pkg::dq_bus_t    io_ddr3_dq;
    wire phy_serdes_pkg::lane_mask_t io_ddr3_dqs, io_ddr3_dqs_n;

    // Bus model of the DDR3 device during reads
    logic                       model_en;
    logic [2:0]                 model_beat = '0;
    phy_serdes_pkg::beat_word_t model_word [phy_serdes_pkg::LANES];
    phy_serdes_pkg::dq_bus_t    model_dq;
    phy_serdes_pkg::lane_mask_t model_dqs;

    // Test table
    int           tbl_kind    [NUM_TESTS];
    logic [127:0] tbl_stim    [NUM_TESTS];
    logic         tbl_dq_rel  [NUM_TESTS];
    logic         tbl_dqs_rel [NUM_TESTS];
    logic         tbl_toggle  [NUM_TESTS];
    int           tbl_slips   [NUM_TESTS];
    int           tbl_count = 0;

    int          mismatch_cnt = 0;
    int          other_cnt    = 0;
    logic [31:0] rng_state    = 32'd10753;

    always #(CTL_PERIOD / 2) i_controller_clk = ~i_controller_clk;
    always #1 i_ddr3_clk = ~i_ddr3_clk;   // Four DDR3 clocks per controller clock

    ddr3_phy u_dut (
        .i_controller_clk             (i_controller_clk),
        .i_ddr3_clk                   (i_ddr3_clk),
        .i_rst_n                      (i_rst_n),
        .i_controller_cmd             (i_controller_cmd),
        .i_controller_dqs_tri_control (dqs_tri),
        .i_controller_dq_tri_control  (dq_tri),
        .i_controller_toggle_dqs      (toggle_dqs),
        .i_controller_data            (i_controller_data),
        .i_controller_bitslip         (i_controller_bitslip),
        .o_controller_iserdes_data    (o_controller_iserdes_data),
        .o_controller_iserdes_dqs     (o_controller_iserdes_dqs),
        .o_ddr3_reset_n               (o_ddr3_reset_n),
        .o_ddr3_cke                   (o_ddr3_cke),
        .o_ddr3_cs_n                  (o_ddr3_cs_n),
        .o_ddr3_ras_n                 (o_ddr3_ras_n),
        .o_ddr3_cas_n                 (o_ddr3_cas_n),
        .o_ddr3_we_n                  (o_ddr3_we_n),
        .o_ddr3_addr                  (o_ddr3_addr),
        .o_ddr3_ba_addr               (o_ddr3_ba_addr),
        .io_ddr3_dq                   (io_ddr3_dq),
        .io_ddr3_dqs                  (io_ddr3_dqs),
        .io_ddr3_dqs_n                (io_ddr3_dqs_n),
        .o_ddr3_odt                   (o_ddr3_odt)
    );

    // New beat every half DDR3 clock, odd bits carry the inverted word
    always @(i_ddr3_clk) begin
        for (int b = 0; b < DQW; b++)
            model_dq[b] <= model_word[b / LBITS][model_beat] ^ b[0];
        model_dqs  <= {phy_serdes_pkg::LANES{~model_beat[0]}};   // 1,0,1,0 strobe
        model_beat <= model_beat + 1'b1;
    end

    assign io_ddr3_dq    = model_en ? model_dq : 'z;
    assign io_ddr3_dqs   = model_en ? model_dqs : 'z;
    assign io_ddr3_dqs_n = model_en ? ~model_dqs : 'z;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Slice n takes beat n+r of the word
    function automatic phy_serdes_pkg::beat_word_t rotate_word(
        input phy_serdes_pkg::beat_word_t w, input int r);
        phy_serdes_pkg::beat_word_t res;
        for (int n = 0; n < BEATS; n++)
            res[n] = w[(n + r) % BEATS];
        return res;
    endfunction

    function automatic phy_serdes_pkg::beat_word_t lane_bits(
        input phy_serdes_pkg::ctrl_data_t data, input int lane, input int b);
        phy_serdes_pkg::beat_word_t res;
        for (int n = 0; n < BEATS; n++)
            res[n] = data[n*DQW + lane*LBITS + b];
        return res;
    endfunction

    function automatic phy_serdes_pkg::ctrl_data_t slip_data(
        input phy_serdes_pkg::ctrl_data_t prev, input int lane);
        phy_serdes_pkg::ctrl_data_t res;
        res = prev;   // Other lane untouched
        for (int n = 0; n < BEATS; n++)
            for (int b = 0; b < LBITS; b++)
                res[n*DQW + lane*LBITS + b] = prev[((n + 1) % BEATS)*DQW + lane*LBITS + b];
        return res;
    endfunction

    function automatic phy_serdes_pkg::dqs_bus_t slip_dqs(
        input phy_serdes_pkg::dqs_bus_t prev, input int lane);
        phy_serdes_pkg::dqs_bus_t res;
        res = prev;
        res[lane*BEATS +: BEATS] = rotate_word(prev[lane*BEATS +: BEATS], 1);
        return res;
    endfunction

    task automatic add_entry(input int kind, input logic dq_rel, input logic dqs_rel,
                             input logic toggle, input int slips);
        tbl_kind[tbl_count]    = kind;
        tbl_stim[tbl_count]    = {next_random(), next_random(), next_random(), next_random()};
        tbl_dq_rel[tbl_count]  = dq_rel;
        tbl_dqs_rel[tbl_count] = dqs_rel;
        tbl_toggle[tbl_count]  = toggle;
        tbl_slips[tbl_count]   = slips;
        tbl_count++;
    endtask

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else begin
            mismatch_cnt++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Called on a controller edge, walks the eight half DDR3 clocks of that cycle
    task automatic check_frame(input phy_serdes_pkg::cmd_bus_t cmd,
                               input phy_serdes_pkg::ctrl_data_t data,
                               input logic dq_rel, input logic dqs_rel, input logic toggle);
        ddr3_pin_pkg::cmd_slot_t    slot;
        phy_serdes_pkg::dq_bus_t    exp_dq;
        phy_serdes_pkg::lane_mask_t exp_dqs;
        phy_serdes_pkg::lane_mask_t exp_dqs_n;
        for (int n = 0; n < BEATS; n++) begin
            #1;   // Sampled value is the half just finished
            slot      = cmd[(n / 2)*ddr3_pin_pkg::CMD_LEN +: ddr3_pin_pkg::CMD_LEN];
            exp_dq    = dq_rel ? 'z : data[n*DQW +: DQW];
            exp_dqs   = {phy_serdes_pkg::LANES{toggle & ~n[0]}};
            exp_dqs_n = ~exp_dqs;
            if (dqs_rel) begin
                exp_dqs   = 'z;
                exp_dqs_n = 'z;
            end
            if (n[0] == 1'b0) begin   // One slot per DDR3 clock
                check_val("o_ddr3_cs_n", $sampled(o_ddr3_cs_n), slot[ddr3_pin_pkg::CMD_CS_N]);
                check_val("o_ddr3_ras_n", $sampled(o_ddr3_ras_n), slot[ddr3_pin_pkg::CMD_RAS_N]);
                check_val("o_ddr3_cas_n", $sampled(o_ddr3_cas_n), slot[ddr3_pin_pkg::CMD_CAS_N]);
                check_val("o_ddr3_we_n", $sampled(o_ddr3_we_n), slot[ddr3_pin_pkg::CMD_WE_N]);
                check_val("o_ddr3_odt", $sampled(o_ddr3_odt), slot[ddr3_pin_pkg::CMD_ODT]);
                check_val("o_ddr3_cke", $sampled(o_ddr3_cke), slot[ddr3_pin_pkg::CMD_CKE]);
                check_val("o_ddr3_reset_n", $sampled(o_ddr3_reset_n),
                          slot[ddr3_pin_pkg::CMD_RESET_N]);
                check_val("o_ddr3_ba_addr", $sampled(o_ddr3_ba_addr),
                          slot[ddr3_pin_pkg::CMD_BANK_LSB +: ddr3_pin_pkg::BA_BITS]);
                check_val("o_ddr3_addr", $sampled(o_ddr3_addr),
                          slot[ddr3_pin_pkg::CMD_ROW_LSB +: ddr3_pin_pkg::ROW_BITS]);
            end
            check_val("io_ddr3_dq", $sampled(io_ddr3_dq), exp_dq);
            check_val("io_ddr3_dqs", $sampled(io_ddr3_dqs), exp_dqs);
            check_val("io_ddr3_dqs_n", $sampled(io_ddr3_dqs_n), exp_dqs_n);
        end
        @(negedge i_controller_clk);
    endtask

    // Each lane must carry some rotation of its driven word
    task automatic check_read_frame(input phy_serdes_pkg::ctrl_data_t data,
                                    input phy_serdes_pkg::dqs_bus_t dqs);
        int                         rot;
        phy_serdes_pkg::beat_word_t dqs_byte;
        for (int l = 0; l < phy_serdes_pkg::LANES; l++) begin
            rot = -1;
            for (int r = BEATS - 1; r >= 0; r--)
                if (lane_bits(data, l, 0) === rotate_word(model_word[l], r))
                    rot = r;
            assert (rot >= 0) else begin
                other_cnt++;
                $display("Lane %0d read data is not a rotation of the driven word", l);
            end
            if (rot >= 0)
                for (int b = 1; b < LBITS; b++)
                    check_val("o_controller_iserdes_data", lane_bits(data, l, b),
                              rotate_word(model_word[l] ^ {BEATS{b[0]}}, rot));
            dqs_byte = dqs[l*BEATS +: BEATS];
            assert (dqs_byte == 8'h55 || dqs_byte == 8'haa) else begin
                other_cnt++;
                $display("Lane %0d read DQS is not the alternating strobe pattern", l);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        other_cnt++;
        $display("Watchdog expired before the test table was finished");
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        phy_serdes_pkg::ctrl_data_t prev_data;
        phy_serdes_pkg::dqs_bus_t   prev_dqs;
        int                         lane;
        i_rst_n              = 1'b0;
        i_controller_cmd     = '0;
        i_controller_data    = '0;
        dq_tri               = 1'b1;
        dqs_tri              = 1'b1;
        toggle_dqs           = 1'b0;
        i_controller_bitslip = '0;
        model_en             = 1'b0;
        model_word[0]        = '0;
        model_word[1]        = '0;

        add_entry(K_CMD, 1'b1, 1'b1, 1'b0, 0);
        add_entry(K_CMD, 1'b1, 1'b1, 1'b0, 0);
        add_entry(K_WR, 1'b0, 1'b0, 1'b1, 0);
        add_entry(K_WR, 1'b0, 1'b0, 1'b0, 0);   // Strobe held low
        add_entry(K_WR, 1'b1, 1'b0, 1'b1, 0);   // DQ released
        add_entry(K_WR, 1'b0, 1'b1, 1'b1, 0);   // DQS released
        add_entry(K_RD, 1'b1, 1'b1, 1'b0, 3);
        add_entry(K_RD, 1'b1, 1'b1, 1'b0, 2);

        repeat (2) @(posedge i_controller_clk);
        i_rst_n <= 1'b1;
        @(posedge i_controller_clk);
        check_frame('0, '0, 1'b1, 1'b1, 1'b0);   // Idle pins right after reset

        for (int t = 0; t < tbl_count; t++) begin
            @(posedge i_controller_clk);
            if (tbl_kind[t] != K_RD) begin
                i_controller_cmd  <= (tbl_kind[t] == K_CMD) ?
                                     phy_serdes_pkg::cmd_bus_t'(tbl_stim[t]) : '0;
                i_controller_data <= (tbl_kind[t] == K_WR) ? tbl_stim[t] : '0;
                dq_tri            <= tbl_dq_rel[t];
                dqs_tri           <= tbl_dqs_rel[t];
                toggle_dqs        <= tbl_toggle[t];
                @(posedge i_controller_clk);   // Captured here, back to idle
                i_controller_cmd  <= '0;
                i_controller_data <= '0;
                dq_tri            <= 1'b1;
                dqs_tri           <= 1'b1;
                toggle_dqs        <= 1'b0;
                @(posedge i_controller_clk);
                check_frame((tbl_kind[t] == K_CMD) ? phy_serdes_pkg::cmd_bus_t'(tbl_stim[t]) : '0,
                            (tbl_kind[t] == K_WR) ? tbl_stim[t] : '0,
                            tbl_dq_rel[t], tbl_dqs_rel[t], tbl_toggle[t]);
            end else begin
                model_word[0] <= phy_serdes_pkg::beat_word_t'(next_random());
                model_word[1] <= phy_serdes_pkg::beat_word_t'(next_random());
                model_en      <= 1'b1;
                repeat (6) @(posedge i_controller_clk);   // Past the read latency
                check_read_frame($sampled(o_controller_iserdes_data),
                                 $sampled(o_controller_iserdes_dqs));
                for (int j = 0; j < tbl_slips[t]; j++) begin
                    lane      = j % phy_serdes_pkg::LANES;   // Alternate lanes
                    prev_data = $sampled(o_controller_iserdes_data);
                    prev_dqs  = $sampled(o_controller_iserdes_dqs);
                    i_controller_bitslip <= phy_serdes_pkg::lane_mask_t'(1 << lane);
                    @(posedge i_controller_clk);
                    i_controller_bitslip <= '0;
                    repeat (3) @(posedge i_controller_clk);
                    check_val("o_controller_iserdes_data", $sampled(o_controller_iserdes_data),
                              slip_data(prev_data, lane));
                    check_val("o_controller_iserdes_dqs", $sampled(o_controller_iserdes_dqs),
                              slip_dqs(prev_dqs, lane));
                    check_read_frame($sampled(o_controller_iserdes_data),
                                     $sampled(o_controller_iserdes_dqs));
                end
                model_en <= 1'b0;
            end
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- list.f
ddr3_pin_pkg.sv
phy_serdes_pkg.sv
cmd_slot_decode.sv
dq_write_serializer.sv
dq_read_deserializer.sv
ddr3_phy.sv
tb_ddr3_phy.sv
